/* logic/xbar_defs.svh */
// Crossbar sizing macros: port count, word and ID widths, table depth, MTU
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// ----------------------------------------------------------------------
// Port geometry
// ----------------------------------------------------------------------
`define XB_NPORTS        4
`define XB_PORT_W        2

// ----------------------------------------------------------------------
// Stream payload
// ----------------------------------------------------------------------
`define XB_DATA_W        64
// Endpoint ID sits in the low bits of the first word
`define XB_EPID_W        16

// ----------------------------------------------------------------------
// Routing table and buffering
// ----------------------------------------------------------------------
`define XB_TBL_DEPTH     8
`define XB_TBL_IDX_W     3
`define XB_MTU_WORDS     32
// Fail-safe output for unmapped IDs
`define XB_DEFAULT_PORT  0

`endif

/* logic/xbar_pkg.sv */
// Crossbar types: data, ID and port vectors, FSM states, round-robin pick
`include "xbar_defs.svh"

package xbar_pkg;

  // Meaningful widths
  typedef logic [`XB_DATA_W-1:0] word_t;
  typedef logic [`XB_EPID_W-1:0] epid_t;
  typedef logic [`XB_PORT_W-1:0] port_t;
  typedef logic [`XB_NPORTS-1:0] port_mask_t;
  // Config word, low bits carry the port
  typedef logic [31:0]           cfg_data_t;

  // Ingress FSM
  typedef enum logic [1:0] {
    IN_IDLE,
    IN_FILL,
    IN_LOOKUP,
    IN_SEND
  } ingress_state_t;

  // Egress FSM
  typedef enum logic {
    EG_ALLOC,
    EG_PACKET
  } egress_state_t;

  // Next requester after last, last itself has lowest priority
  function automatic port_t rr_next(input port_mask_t req, input port_t last);
    port_t       pick;
    int unsigned idx;
    pick = last;
    // Walk backwards so the closest port after last wins
    for (int i = `XB_NPORTS; i >= 1; i--) begin
      idx = (int'(last) + i) % `XB_NPORTS;
      if (req[idx]) begin
        pick = port_t'(idx);
      end
    end
    return pick;
  endfunction

endpackage

/* logic/route_table.sv */
// Shared endpoint-ID to port table with FIFO replacement and lookup port
`timescale 1ns/1ps
`include "xbar_defs.svh"

module route_table
  import xbar_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Configuration write port
  input  logic      i_cfg_stb,
  input  epid_t     i_cfg_addr,
  input  cfg_data_t i_cfg_data,
  output logic      o_cfg_ack,
  // Lookup port
  input  logic      i_find_valid,
  input  epid_t     i_find_epid,
  output logic      o_result_valid,
  output logic      o_result_hit,
  output port_t     o_result_port
);

  typedef logic [`XB_TBL_IDX_W-1:0] tbl_idx_t;

  // Table entries
  logic [`XB_TBL_DEPTH-1:0] ent_valid;
  epid_t                    ent_epid [`XB_TBL_DEPTH];
  port_t                    ent_port [`XB_TBL_DEPTH];
  // Oldest slot, next to be replaced
  tbl_idx_t                 repl_ptr;

  logic     cfg_hit;
  tbl_idx_t cfg_idx;
  logic     find_hit;
  port_t    find_port;

  // ----------------------------------------------------------------------
  // Match logic
  // ----------------------------------------------------------------------

  // Config write target, existing entry or replacement slot
  always_comb begin
    cfg_hit = 1'b0;
    cfg_idx = repl_ptr;
    for (int k = 0; k < `XB_TBL_DEPTH; k++) begin
      if (ent_valid[k] && (ent_epid[k] == i_cfg_addr)) begin
        cfg_hit = 1'b1;
        cfg_idx = tbl_idx_t'(k);
      end
    end
  end

  // Lookup compare against all entries
  // Reads registered contents, so a write in the same cycle is not seen
  always_comb begin
    find_hit  = 1'b0;
    find_port = port_t'(`XB_DEFAULT_PORT);
    for (int k = 0; k < `XB_TBL_DEPTH; k++) begin
      if (ent_valid[k] && (ent_epid[k] == i_find_epid)) begin
        find_hit  = 1'b1;
        find_port = ent_port[k];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_valid      <= '0;
      repl_ptr       <= '0;
      o_cfg_ack      <= 1'b0;
      o_result_valid <= 1'b0;
    end else begin
      // Ack and result follow their strobes by one cycle
      o_cfg_ack      <= i_cfg_stb;
      o_result_valid <= i_find_valid;
      if (i_cfg_stb) begin
        ent_valid[cfg_idx] <= 1'b1;
        // New ID consumed the oldest slot
        if (!cfg_hit) begin
          repl_ptr <= repl_ptr + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Entry contents and lookup result
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (i_cfg_stb) begin
      ent_epid[cfg_idx] <= i_cfg_addr;
      ent_port[cfg_idx] <= i_cfg_data[`XB_PORT_W-1:0];
    end
    if (i_find_valid) begin
      o_result_hit  <= find_hit;
      o_result_port <= find_port;
    end
  end

endmodule

/* logic/lookup_arbiter.sv */
// Round-robin arbiter serializing ingress ID lookups onto the routing table
`timescale 1ns/1ps
`include "xbar_defs.svh"

module lookup_arbiter
  import xbar_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  // Requests from ingress ports
  input  port_mask_t               i_req_valid,
  input  epid_t [`XB_NPORTS-1:0]   i_req_epid,
  // Table lookup port
  output logic                     o_find_valid,
  output epid_t                    o_find_epid,
  input  logic                     i_result_valid,
  input  logic                     i_result_hit,
  input  port_t                    i_result_port,
  // Grant and response back to ingress ports
  output port_mask_t               o_grant,
  output port_mask_t               o_resp_valid,
  output logic                     o_resp_hit,
  output port_t                    o_resp_port
);

  // Most recently granted requester
  port_t last_q;
  port_t pick;
  // A lookup is in flight while any grant is held
  logic  busy;

  assign busy = |o_grant;
  assign pick = rr_next(i_req_valid, last_q);

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------

  // One lookup per two cycles, issue only when idle
  assign o_find_valid = !busy && (|i_req_valid);
  assign o_find_epid  = i_req_epid[pick];

  // ----------------------------------------------------------------------
  // Response side
  // ----------------------------------------------------------------------

  // Result pulse goes to the granted port only
  assign o_resp_valid = i_result_valid ? o_grant : '0;
  assign o_resp_hit   = i_result_hit;
  assign o_resp_port  = i_result_port;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_grant <= '0;
      // Port 0 wins first after reset
      last_q  <= port_t'(`XB_NPORTS - 1);
    end else if (o_find_valid) begin
      o_grant <= port_mask_t'(1) << pick;
      last_q  <= pick;
    end else if (i_result_valid) begin
      // Table answered, free for the next lookup
      o_grant <= '0;
    end
  end

endmodule

/* logic/ingress_port.sv */
// Ingress packet buffer with ID lookup and destination demultiplexer
`timescale 1ns/1ps
`include "xbar_defs.svh"

module ingress_port
  import xbar_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Input stream
  input  word_t      i_s_tdata,
  input  logic       i_s_tlast,
  input  logic       i_s_tvalid,
  output logic       o_s_tready,
  // Lookup request and response
  output logic       o_find_valid,
  output epid_t      o_find_epid,
  input  logic       i_grant,
  input  logic       i_resp_valid,
  input  logic       i_resp_hit,
  input  port_t      i_resp_port,
  // Toward the egress multiplexers
  output word_t      o_tdata,
  output logic       o_tlast,
  output port_mask_t o_dst_valid,
  input  port_mask_t i_dst_ready
);

  localparam int ADDR_W = $clog2(`XB_MTU_WORDS);

  typedef logic [ADDR_W-1:0] addr_t;

  ingress_state_t state;
  // One packet of storage, packets are at most MTU words
  word_t          pkt_mem [`XB_MTU_WORDS];
  addr_t          wr_ptr;
  addr_t          rd_ptr;
  addr_t          last_idx;
  epid_t          epid_q;
  port_t          dst_q;
  logic           wr_en;
  logic           rd_en;

  // ----------------------------------------------------------------------
  // Handshakes and outputs
  // ----------------------------------------------------------------------

  // Accept words until the packet is complete
  assign o_s_tready = (state == IN_IDLE) || (state == IN_FILL);
  assign wr_en      = o_s_tready && i_s_tvalid;

  // Withdraw request while the lookup is in flight
  assign o_find_valid = (state == IN_LOOKUP) && !i_grant;
  assign o_find_epid  = epid_q;

  // Same word fans out to every destination
  assign o_tdata     = pkt_mem[rd_ptr];
  assign o_tlast     = (rd_ptr == last_idx);
  assign o_dst_valid = (state == IN_SEND) ? (port_mask_t'(1) << dst_q) : '0;
  assign rd_en       = |(o_dst_valid & i_dst_ready);

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IN_IDLE;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      case (state)
        IN_IDLE, IN_FILL: begin
          if (wr_en) begin
            if (i_s_tlast) begin
              wr_ptr <= '0;
              state  <= IN_LOOKUP;
            end else begin
              wr_ptr <= wr_ptr + 1'b1;
              state  <= IN_FILL;
            end
          end
        end
        IN_LOOKUP: begin
          if (i_resp_valid) begin
            state <= IN_SEND;
          end
        end
        IN_SEND: begin
          // Stalled destination holds the packet here
          if (rd_en) begin
            if (o_tlast) begin
              rd_ptr <= '0;
              state  <= IN_IDLE;
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end
        end
        default: state <= IN_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Packet storage and routing info
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      pkt_mem[wr_ptr] <= i_s_tdata;
    end
  end

  always_ff @(posedge clk) begin
    // ID from the first word only
    if (wr_en && (state == IN_IDLE)) begin
      epid_q <= i_s_tdata[`XB_EPID_W-1:0];
    end
    if (wr_en && i_s_tlast) begin
      last_idx <= wr_ptr;
    end
    // Miss falls back to the default port
    if (i_resp_valid) begin
      dst_q <= i_resp_hit ? i_resp_port : port_t'(`XB_DEFAULT_PORT);
    end
  end

endmodule

/* logic/egress_mux.sv */
// Round-robin packet-locked output multiplexer with a one-word output register
`timescale 1ns/1ps
`include "xbar_defs.svh"

module egress_mux
  import xbar_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // From every ingress port
  input  word_t [`XB_NPORTS-1:0] i_tdata,
  input  port_mask_t             i_tlast,
  input  port_mask_t             i_valid,
  output port_mask_t             o_ready,
  // Output stream
  output word_t                  o_m_tdata,
  output logic                   o_m_tlast,
  output logic                   o_m_tvalid,
  input  logic                   i_m_tready
);

  egress_state_t state;
  // Current owner, also the round-robin reference
  port_t         owner;
  logic          out_free;
  logic          load;

  // ----------------------------------------------------------------------
  // Datapath control
  // ----------------------------------------------------------------------

  // Output register empty or draining this cycle
  assign out_free = !o_m_tvalid || i_m_tready;

  // Owner word moves into the output register
  assign load = (state == EG_PACKET) && i_valid[owner] && out_free;

  // Only the owner sees ready
  assign o_ready = ((state == EG_PACKET) && out_free) ? (port_mask_t'(1) << owner) : '0;

  // ----------------------------------------------------------------------
  // Allocation FSM and output valid
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= EG_ALLOC;
      owner      <= port_t'(`XB_NPORTS - 1);
      o_m_tvalid <= 1'b0;
    end else begin
      case (state)
        EG_ALLOC: begin
          // Decide once the output can take a word
          if ((|i_valid) && out_free) begin
            owner <= rr_next(i_valid, owner);
            state <= EG_PACKET;
          end
        end
        EG_PACKET: begin
          // Locked until the last word is taken
          if (load && i_tlast[owner]) begin
            state <= EG_ALLOC;
          end
        end
        default: state <= EG_ALLOC;
      endcase

      if (load) begin
        o_m_tvalid <= 1'b1;
      end else if (i_m_tready) begin
        o_m_tvalid <= 1'b0;
      end
    end
  end

  // Output word register
  always_ff @(posedge clk) begin
    if (load) begin
      o_m_tdata <= i_tdata[owner];
      o_m_tlast <= i_tlast[owner];
    end
  end

endmodule

/* logic/chdr_xbar.sv */
// Four-port packet crossbar: ingress buffers, shared route table, egress muxes
`timescale 1ns/1ps
`include "xbar_defs.svh"

module chdr_xbar
  import xbar_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // Input streams
  input  word_t [`XB_NPORTS-1:0] i_s_tdata,
  input  port_mask_t             i_s_tlast,
  input  port_mask_t             i_s_tvalid,
  output port_mask_t             o_s_tready,
  // Output streams
  output word_t [`XB_NPORTS-1:0] o_m_tdata,
  output port_mask_t             o_m_tlast,
  output port_mask_t             o_m_tvalid,
  input  port_mask_t             i_m_tready,
  // Routing table configuration
  input  logic                   i_cfg_stb,
  input  epid_t                  i_cfg_addr,
  input  cfg_data_t              i_cfg_data,
  output logic                   o_cfg_ack
);

  // Lookup path
  port_mask_t               find_valid;
  epid_t [`XB_NPORTS-1:0]   find_epid;
  port_mask_t               grant;
  port_mask_t               resp_valid;
  logic                     resp_hit;
  port_t                    resp_port;
  logic                     tbl_find_valid;
  epid_t                    tbl_find_epid;
  logic                     tbl_result_valid;
  logic                     tbl_result_hit;
  port_t                    tbl_result_port;

  // Crossbar path, [input][output] on the ingress side, [output][input] on egress
  word_t [`XB_NPORTS-1:0]      in_tdata;
  port_mask_t                  in_tlast;
  port_mask_t [`XB_NPORTS-1:0] dst_valid;
  port_mask_t [`XB_NPORTS-1:0] dst_ready;
  port_mask_t [`XB_NPORTS-1:0] mux_valid;
  port_mask_t [`XB_NPORTS-1:0] mux_ready;

  // ----------------------------------------------------------------------
  // Shared routing table and its arbiter
  // ----------------------------------------------------------------------

  route_table u_route_table (
    .clk           (clk),
    .reset         (reset),
    .i_cfg_stb     (i_cfg_stb),
    .i_cfg_addr    (i_cfg_addr),
    .i_cfg_data    (i_cfg_data),
    .o_cfg_ack     (o_cfg_ack),
    .i_find_valid  (tbl_find_valid),
    .i_find_epid   (tbl_find_epid),
    .o_result_valid(tbl_result_valid),
    .o_result_hit  (tbl_result_hit),
    .o_result_port (tbl_result_port)
  );

  lookup_arbiter u_lookup_arbiter (
    .clk           (clk),
    .reset         (reset),
    .i_req_valid   (find_valid),
    .i_req_epid    (find_epid),
    .o_find_valid  (tbl_find_valid),
    .o_find_epid   (tbl_find_epid),
    .i_result_valid(tbl_result_valid),
    .i_result_hit  (tbl_result_hit),
    .i_result_port (tbl_result_port),
    .o_grant       (grant),
    .o_resp_valid  (resp_valid),
    .o_resp_hit    (resp_hit),
    .o_resp_port   (resp_port)
  );

  // ----------------------------------------------------------------------
  // Ports and crossbar wiring
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < `XB_NPORTS; i++) begin : gen_ingress
    ingress_port u_ingress (
      .clk         (clk),
      .reset       (reset),
      .i_s_tdata   (i_s_tdata[i]),
      .i_s_tlast   (i_s_tlast[i]),
      .i_s_tvalid  (i_s_tvalid[i]),
      .o_s_tready  (o_s_tready[i]),
      .o_find_valid(find_valid[i]),
      .o_find_epid (find_epid[i]),
      .i_grant     (grant[i]),
      .i_resp_valid(resp_valid[i]),
      .i_resp_hit  (resp_hit),
      .i_resp_port (resp_port),
      .o_tdata     (in_tdata[i]),
      .o_tlast     (in_tlast[i]),
      .o_dst_valid (dst_valid[i]),
      .i_dst_ready (dst_ready[i])
    );

    // Transpose input-major to output-major
    for (genvar j = 0; j < `XB_NPORTS; j++) begin : gen_route
      assign mux_valid[j][i] = dst_valid[i][j];
      assign dst_ready[i][j] = mux_ready[j][i];
    end
  end

  for (genvar j = 0; j < `XB_NPORTS; j++) begin : gen_egress
    egress_mux u_egress (
      .clk       (clk),
      .reset     (reset),
      .i_tdata   (in_tdata),
      .i_tlast   (in_tlast),
      .i_valid   (mux_valid[j]),
      .o_ready   (mux_ready[j]),
      .o_m_tdata (o_m_tdata[j]),
      .o_m_tlast (o_m_tlast[j]),
      .o_m_tvalid(o_m_tvalid[j]),
      .i_m_tready(i_m_tready[j])
    );
  end

endmodule

/* tests/xbar_checker.sv */
// Crossbar scoreboard: routing table model, per-pair packet queues, output compare
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_checker
  import xbar_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // Input streams as seen by the DUT
  input  word_t [`XB_NPORTS-1:0] i_s_tdata,
  input  port_mask_t             i_s_tlast,
  input  port_mask_t             i_s_tvalid,
  input  port_mask_t             i_s_tready,
  // Output streams
  input  word_t [`XB_NPORTS-1:0] i_m_tdata,
  input  port_mask_t             i_m_tlast,
  input  port_mask_t             i_m_tvalid,
  input  port_mask_t             i_m_tready,
  // Configuration port
  input  logic                   i_cfg_stb,
  input  epid_t                  i_cfg_addr,
  input  cfg_data_t              i_cfg_data,
  input  logic                   i_cfg_ack,
  // Port the stimulus expects for the packet on each input
  input  port_t [`XB_NPORTS-1:0] i_exp_port,
  output int                     o_data_errors,
  output int                     o_ctrl_errors,
  output int                     o_pending
);

  // Last flag on top of the data word
  typedef logic [`XB_DATA_W:0] entry_t;

  // Table model
  logic [`XB_TBL_DEPTH-1:0] m_valid;
  epid_t                    m_epid [`XB_TBL_DEPTH];
  port_t                    m_port [`XB_TBL_DEPTH];
  int                       m_ptr;

  // Partial input packets, then expected words per input*N+output
  entry_t in_pkt [`XB_NPORTS][$];
  entry_t exp_q  [`XB_NPORTS*`XB_NPORTS][$];
  logic [`XB_NPORTS-1:0] out_busy;
  int                    out_src [`XB_NPORTS];
  logic                  cfg_stb_d;

  // ----------------------------------------------------------------------
  // Table model
  // ----------------------------------------------------------------------

  // Unknown IDs go to the default port
  function automatic port_t model_route(input epid_t id);
    port_t p;
    p = port_t'(`XB_DEFAULT_PORT);
    for (int k = 0; k < `XB_TBL_DEPTH; k++) begin
      if (m_valid[k] && m_epid[k] == id) begin
        p = m_port[k];
      end
    end
    return p;
  endfunction

  // Known ID updates in place, new ID replaces the oldest slot
  task automatic model_write(input epid_t id, input port_t p);
    int slot;
    slot = -1;
    for (int k = 0; k < `XB_TBL_DEPTH; k++) begin
      if (m_valid[k] && m_epid[k] == id) begin
        slot = k;
      end
    end
    if (slot < 0) begin
      slot  = m_ptr;
      m_ptr = (m_ptr + 1) % `XB_TBL_DEPTH;
    end
    m_valid[slot] = 1'b1;
    m_epid[slot]  = id;
    m_port[slot]  = p;
  endtask

  // ----------------------------------------------------------------------
  // Input capture and output compare
  // ----------------------------------------------------------------------

  task automatic capture_input(input int p);
    entry_t head;
    port_t  dst;
    in_pkt[p].push_back({i_s_tlast[p], i_s_tdata[p]});
    if (i_s_tlast[p]) begin
      head = in_pkt[p][0];
      dst  = model_route(head[`XB_EPID_W-1:0]);
      if (dst !== i_exp_port[p]) begin
        $display("error t=%0t route_port[%0d] expected %0d got %0d",
                 $time, p, i_exp_port[p], dst);
        o_ctrl_errors++;
      end
      while (in_pkt[p].size() > 0) begin
        exp_q[p*`XB_NPORTS + dst].push_back(in_pkt[p].pop_front());
      end
      o_pending++;
    end
  endtask

  task automatic check_output(input int j);
    entry_t want;
    int     q;
    // Source field of the first word locks the queue for the packet
    if (!out_busy[j]) begin
      out_src[j]  = int'(i_m_tdata[j][19:16]);
      out_busy[j] = 1'b1;
    end
    q = out_src[j]*`XB_NPORTS + j;
    if (out_src[j] >= `XB_NPORTS || exp_q[q].size() == 0) begin
      $display("t=%0t output %0d delivered a word that no packet from input %0d explains",
               $time, j, out_src[j]);
      o_ctrl_errors++;
    end else begin
      want = exp_q[q].pop_front();
      if (i_m_tdata[j] !== want[`XB_DATA_W-1:0]) begin
        $display("error t=%0t o_m_tdata[%0d] expected %h got %h",
                 $time, j, want[`XB_DATA_W-1:0], i_m_tdata[j]);
        o_data_errors++;
      end
      if (i_m_tlast[j] !== want[`XB_DATA_W]) begin
        $display("error t=%0t o_m_tlast[%0d] expected %0b got %0b",
                 $time, j, want[`XB_DATA_W], i_m_tlast[j]);
        o_data_errors++;
      end
    end
    if (i_m_tlast[j]) begin
      out_busy[j] = 1'b0;
      o_pending--;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      m_valid       = '0;
      m_ptr         = 0;
      out_busy      = '0;
      cfg_stb_d     = 1'b0;
      o_data_errors = 0;
      o_ctrl_errors = 0;
      o_pending     = 0;
      for (int p = 0; p < `XB_NPORTS; p++) begin
        in_pkt[p].delete();
      end
    end else begin
      // Ack must mirror the strobe one cycle late
      if (i_cfg_ack !== cfg_stb_d) begin
        $display("error t=%0t o_cfg_ack expected %0b got %0b", $time, cfg_stb_d, i_cfg_ack);
        o_ctrl_errors++;
      end
      cfg_stb_d = i_cfg_stb;
      for (int p = 0; p < `XB_NPORTS; p++) begin
        if (i_s_tvalid[p] && i_s_tready[p]) begin
          capture_input(p);
        end
        if (i_m_tvalid[p] && i_m_tready[p]) begin
          check_output(p);
        end
      end
      // Table write lands after this edge's lookups
      if (i_cfg_stb) begin
        model_write(i_cfg_addr, i_cfg_data[`XB_PORT_W-1:0]);
      end
    end
  end

endmodule

/* tests/chdr_xbar_assert.sv */
// Crossbar protocol assertions on output streams, config ack and reset
`timescale 1ns/1ps
`include "xbar_defs.svh"

module chdr_xbar_assert
  import xbar_pkg::*;
(
  input logic                   clk,
  input logic                   reset,
  input logic                   i_cfg_stb,
  input logic                   i_cfg_ack,
  input word_t [`XB_NPORTS-1:0] i_out_data,
  input port_mask_t             i_out_last,
  input port_mask_t             i_out_valid,
  input port_mask_t             i_out_ready
);

  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Configuration handshake
  // ----------------------------------------------------------------------

  // Every strobe gets its ack on the next cycle
  a_ack_follows_stb: assert property (@(posedge clk) disable iff (reset)
    i_cfg_stb |=> i_cfg_ack)
    else begin
      $error("o_cfg_ack missing one cycle after i_cfg_stb");
      fail_count++;
    end

  // No ack without a strobe the cycle before
  a_ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
    i_cfg_ack |-> $past(i_cfg_stb))
    else begin
      $error("o_cfg_ack pulsed without a preceding i_cfg_stb");
      fail_count++;
    end

  // Outputs quiet while reset is applied
  a_reset_quiet: assert property (@(posedge clk)
    reset |=> (i_out_valid == '0))
    else begin
      $error("o_m_tvalid high during reset");
      fail_count++;
    end

  // ----------------------------------------------------------------------
  // Output streams
  // ----------------------------------------------------------------------

  for (genvar j = 0; j < `XB_NPORTS; j++) begin : gen_out
    // Stalled word stays put until taken
    a_hold_until_ready: assert property (@(posedge clk) disable iff (reset)
      (i_out_valid[j] && !i_out_ready[j]) |=>
        (i_out_valid[j] && $stable(i_out_data[j]) && $stable(i_out_last[j])))
      else begin
        $error("output %0d dropped or changed a word before ready", j);
        fail_count++;
      end
  end

endmodule

/* tests/chdr_xbar_tb.sv */
// Crossbar testbench with table-driven config writes and packets under back-pressure
`timescale 1ns/1ps
`include "xbar_defs.svh"

module chdr_xbar_tb
  import xbar_pkg::*;
();

  localparam int K_CFG       = 0;
  localparam int K_PKT       = 1;
  localparam int K_SYNC      = 2;
  localparam int K_BP        = 3;
  localparam int NUM_ROWS    = 50;
  localparam int HS_LIMIT    = 5000;
  localparam int ACK_LIMIT   = 4;
  localparam int DRAIN_LIMIT = 20000;

  typedef struct {
    int kind;
    int port;  // Input port, table port or back-pressure enable
    int id;
    int len;   // Zero picks a random length
    int exp;   // Expected output port
  } row_t;

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------

  row_t rows [NUM_ROWS] = '{
    // Basic routes plus one miss
    '{K_CFG, 1, 'h0101, 0, 0}, '{K_CFG, 2, 'h0202, 0, 0}, '{K_CFG, 3, 'h0303, 0, 0},
    '{K_PKT, 0, 'h0101, 4, 1}, '{K_PKT, 1, 'h0202, 1, 2}, '{K_PKT, 2, 'h0303, 32, 3},
    '{K_PKT, 3, 'h0777, 5, 0}, '{K_PKT, 0, 'h0202, 3, 2},
    // Rewrite of a known ID
    '{K_CFG, 3, 'h0101, 0, 0},
    '{K_PKT, 0, 'h0101, 3, 3}, '{K_PKT, 2, 'h0101, 2, 3},
    // Six more new IDs so the ninth evicts 0x0101
    '{K_CFG, 1, 'h1000, 0, 0}, '{K_CFG, 2, 'h1001, 0, 0}, '{K_CFG, 3, 'h1002, 0, 0},
    '{K_CFG, 0, 'h1003, 0, 0}, '{K_CFG, 1, 'h1004, 0, 0}, '{K_CFG, 2, 'h1005, 0, 0},
    '{K_PKT, 1, 'h0101, 2, 0}, '{K_PKT, 2, 'h0202, 6, 2}, '{K_PKT, 3, 'h1000, 7, 1},
    '{K_PKT, 0, 'h1005, 1, 2}, '{K_SYNC, 0, 0, 0, 0},
    // All inputs into output 3 at once
    '{K_PKT, 0, 'h0303, 8, 3}, '{K_PKT, 1, 'h0303, 8, 3}, '{K_PKT, 2, 'h0303, 8, 3},
    '{K_PKT, 3, 'h0303, 8, 3}, '{K_PKT, 0, 'h0303, 2, 3}, '{K_PKT, 1, 'h0303, 2, 3},
    '{K_PKT, 2, 'h0303, 2, 3}, '{K_PKT, 3, 'h0303, 2, 3}, '{K_SYNC, 0, 0, 0, 0},
    // Random lengths under random output back-pressure
    '{K_BP, 1, 0, 0, 0},
    '{K_PKT, 0, 'h1000, 0, 1}, '{K_PKT, 1, 'h0303, 0, 3}, '{K_PKT, 2, 'h1003, 0, 0},
    '{K_PKT, 3, 'h0202, 0, 2}, '{K_PKT, 0, 'h0202, 0, 2}, '{K_PKT, 1, 'h1000, 0, 1},
    '{K_PKT, 2, 'h0303, 0, 3}, '{K_PKT, 3, 'h0999, 0, 0}, '{K_PKT, 0, 'h0303, 0, 3},
    '{K_PKT, 1, 'h0101, 0, 0}, '{K_PKT, 2, 'h1000, 0, 1}, '{K_PKT, 3, 'h1004, 0, 1},
    '{K_PKT, 0, 'h1003, 0, 0}, '{K_PKT, 1, 'h0202, 0, 2}, '{K_PKT, 2, 'h0202, 0, 2},
    '{K_PKT, 3, 'h0303, 0, 3}, '{K_SYNC, 0, 0, 0, 0},
    '{K_BP, 0, 0, 0, 0}
  };

  logic                   clk;
  logic                   reset;
  word_t [`XB_NPORTS-1:0] s_tdata;
  port_mask_t             s_tlast;
  port_mask_t             s_tvalid;
  port_mask_t             s_tready;
  word_t [`XB_NPORTS-1:0] m_tdata;
  port_mask_t             m_tlast;
  port_mask_t             m_tvalid;
  port_mask_t             m_tready;
  logic                   cfg_stb;
  epid_t                  cfg_addr;
  cfg_data_t              cfg_data;
  logic                   cfg_ack;
  port_t [`XB_NPORTS-1:0] exp_port;
  int                     data_errors;
  int                     ctrl_errors;
  int                     pending;
  integer                 seed = 32'hf466_5158;
  int                     seq;
  logic                   bp_on;
  // Packet rows waiting per input port
  int                     pend_q [`XB_NPORTS][$];

  chdr_xbar DUT (
    .clk       (clk),
    .reset     (reset),
    .i_s_tdata (s_tdata),
    .i_s_tlast (s_tlast),
    .i_s_tvalid(s_tvalid),
    .o_s_tready(s_tready),
    .o_m_tdata (m_tdata),
    .o_m_tlast (m_tlast),
    .o_m_tvalid(m_tvalid),
    .i_m_tready(m_tready),
    .i_cfg_stb (cfg_stb),
    .i_cfg_addr(cfg_addr),
    .i_cfg_data(cfg_data),
    .o_cfg_ack (cfg_ack)
  );

  xbar_checker u_checker (
    .clk(clk), .reset(reset),
    .i_s_tdata(s_tdata), .i_s_tlast(s_tlast), .i_s_tvalid(s_tvalid), .i_s_tready(s_tready),
    .i_m_tdata(m_tdata), .i_m_tlast(m_tlast), .i_m_tvalid(m_tvalid), .i_m_tready(m_tready),
    .i_cfg_stb(cfg_stb), .i_cfg_addr(cfg_addr), .i_cfg_data(cfg_data), .i_cfg_ack(cfg_ack),
    .i_exp_port(exp_port),
    .o_data_errors(data_errors), .o_ctrl_errors(ctrl_errors), .o_pending(pending)
  );

  bind chdr_xbar chdr_xbar_assert u_assert (
    .clk(clk), .reset(reset), .i_cfg_stb(i_cfg_stb), .i_cfg_ack(o_cfg_ack),
    .i_out_data(o_m_tdata), .i_out_last(o_m_tlast), .i_out_valid(o_m_tvalid),
    .i_out_ready(i_m_tready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Output ready is random only while back-pressure is on
  initial begin
    m_tready = '1;
    forever begin
      @(posedge clk);
      #1;
      m_tready = bp_on ? port_mask_t'($random(seed)) : '1;
    end
  end

  // ----------------------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------------------

  task automatic report_counts(input int timeouts);
    $display("errors: data %0d, control %0d, assertions %0d, timeouts %0d",
             data_errors, ctrl_errors, DUT.u_assert.fail_count, timeouts);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s did not complete in time", what);
    report_counts(1);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic write_cfg(input int id, input int port);
    int waited;
    cfg_addr = epid_t'(id);
    cfg_data = cfg_data_t'(port);
    cfg_stb  = 1'b1;
    @(posedge clk);
    #1;
    cfg_stb = 1'b0;
    waited  = 0;
    @(posedge clk);
    while (cfg_ack !== 1'b1) begin
      waited++;
      if (waited > ACK_LIMIT) stop_on_timeout("configuration ack");
      @(posedge clk);
    end
    #1;
  endtask

  // First word carries ID, source port and sequence number
  task automatic send_packet(input int p, input int r);
    int    len;
    int    waited;
    word_t w;
    len = rows[r].len;
    if (len == 0) begin
      len = 1 + int'($unsigned($random(seed)) % `XB_MTU_WORDS);
    end
    exp_port[p] = port_t'(rows[r].exp);
    for (int k = 0; k < len; k++) begin
      w = {$random(seed), $random(seed)};
      if (k == 0) begin
        w[31:20] = 12'(seq);
        w[19:16] = 4'(p);
        w[15:0]  = 16'(rows[r].id);
        seq      = seq + 1;
      end
      s_tdata[p]  = w;
      s_tlast[p]  = (k == len - 1);
      s_tvalid[p] = 1'b1;
      waited      = 0;
      @(posedge clk);
      while (s_tready[p] !== 1'b1) begin
        waited++;
        if (waited > HS_LIMIT) stop_on_timeout("input stream handshake");
        @(posedge clk);
      end
      #1;
    end
    s_tvalid[p] = 1'b0;
    s_tlast[p]  = 1'b0;
  endtask

  task automatic drive_port(input int p);
    int r;
    while (pend_q[p].size() > 0) begin
      r = pend_q[p].pop_front();
      send_packet(p, r);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    while (pending != 0 || m_tvalid != '0) begin
      waited++;
      if (waited > DRAIN_LIMIT) stop_on_timeout("output drain");
      @(posedge clk);
      #1;
    end
  endtask

  // Queued packets go out on all inputs in parallel
  task automatic flush_traffic();
    fork
      drive_port(0);
      drive_port(1);
      drive_port(2);
      drive_port(3);
    join
    wait_drain();
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    s_tdata  = '0;
    s_tlast  = '0;
    s_tvalid = '0;
    cfg_stb  = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    exp_port = '0;
    bp_on    = 1'b0;
    seq      = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      case (rows[r].kind)
        K_CFG: begin
          // Table changes only once earlier traffic has left
          flush_traffic();
          write_cfg(rows[r].id, rows[r].port);
        end
        K_PKT:   pend_q[rows[r].port].push_back(r);
        K_SYNC:  flush_traffic();
        default: bp_on = (rows[r].port != 0);
      endcase
    end
    flush_traffic();
    report_counts(0);
    if (data_errors == 0 && ctrl_errors == 0 && DUT.u_assert.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* chdr_xbar.f */
+incdir+logic
logic/xbar_pkg.sv
logic/route_table.sv
logic/lookup_arbiter.sv
logic/ingress_port.sv
logic/egress_mux.sv
logic/chdr_xbar.sv
tests/xbar_checker.sv
tests/chdr_xbar_assert.sv
tests/chdr_xbar_tb.sv
